/* hw/ecgPkg.sv */
package ecgPkg;

	// Stream geometry
	localparam int SampleWidth = 8;
	localparam int NumSamples = 187;
	localparam int AddrWidth = 8;

	localparam int RrWidth = 8; // RR interval in samples

	// Detector tuning
	localparam logic [SampleWidth-1:0] PeakThreshold = SampleWidth'(40);
	localparam logic [RrWidth-1:0] RefractorySamples = RrWidth'(20); // Blanking after a peak

endpackage

/* hw/ecgStreamIf.sv */
`timescale 1ns/10ps

interface ecgStreamIf;

	logic valid;
	logic [ecgPkg::SampleWidth-1:0] sample;
	logic [ecgPkg::AddrWidth-1:0] index;
	logic last; // High with the final index of a run

	modport source
	(
		output valid, sample, index, last
	);

	modport sink
	(
		input valid, sample, index, last
	);

endinterface

/* hw/ecgSampleRom.sv */
`timescale 1ns/10ps

module ecgSampleRom
(
	input logic clk,
	input logic [ecgPkg::AddrWidth-1:0] addr,
	output logic [ecgPkg::SampleWidth-1:0] sample
);

	// Stored ECG trace with one cycle of read latency
	always_ff @(posedge clk)
	begin
		case (addr)
			8'd0: sample <= 8'd61; // First QRS complex
			8'd1: sample <= 8'd60;
			8'd2: sample <= 8'd41;
			8'd3: sample <= 8'd19;
			8'd4: sample <= 8'd4;
			8'd5: sample <= 8'd0;
			8'd6: sample <= 8'd3;
			8'd7: sample <= 8'd6;
			8'd8: sample <= 8'd6;
			8'd9: sample <= 8'd6;
			8'd10: sample <= 8'd6;
			8'd11: sample <= 8'd6;
			8'd12: sample <= 8'd7;
			8'd13: sample <= 8'd7;
			8'd14: sample <= 8'd7;
			8'd15: sample <= 8'd8;
			8'd16: sample <= 8'd8;
			8'd17: sample <= 8'd8;
			8'd18: sample <= 8'd8;
			8'd19: sample <= 8'd8;
			8'd20: sample <= 8'd9;
			8'd21: sample <= 8'd10;
			8'd22: sample <= 8'd10;
			8'd23: sample <= 8'd11;
			8'd24: sample <= 8'd11;
			8'd25: sample <= 8'd12;
			8'd26: sample <= 8'd13;
			8'd27: sample <= 8'd14;
			8'd28: sample <= 8'd15;
			8'd29: sample <= 8'd17;
			8'd30: sample <= 8'd18;
			8'd31: sample <= 8'd20;
			8'd32: sample <= 8'd21;
			8'd33: sample <= 8'd22;
			8'd34: sample <= 8'd23; // T wave crest
			8'd35: sample <= 8'd23;
			8'd36: sample <= 8'd23;
			8'd37: sample <= 8'd22;
			8'd38: sample <= 8'd21;
			8'd39: sample <= 8'd19;
			8'd40: sample <= 8'd16;
			8'd41: sample <= 8'd14;
			8'd42: sample <= 8'd12;
			8'd43: sample <= 8'd11;
			8'd44: sample <= 8'd9;
			8'd45: sample <= 8'd9;
			8'd46: sample <= 8'd8;
			8'd47: sample <= 8'd7;
			8'd48: sample <= 8'd7;
			8'd49: sample <= 8'd7;
			8'd50: sample <= 8'd7;
			8'd51: sample <= 8'd7;
			8'd52: sample <= 8'd7;
			8'd53: sample <= 8'd7;
			8'd54: sample <= 8'd7;
			8'd55: sample <= 8'd7;
			8'd56: sample <= 8'd7;
			8'd57: sample <= 8'd7;
			8'd58: sample <= 8'd7;
			8'd59: sample <= 8'd7;
			8'd60: sample <= 8'd7;
			8'd61: sample <= 8'd7;
			8'd62: sample <= 8'd7;
			8'd63: sample <= 8'd7;
			8'd64: sample <= 8'd7;
			8'd65: sample <= 8'd7;
			8'd66: sample <= 8'd7;
			8'd67: sample <= 8'd7;
			8'd68: sample <= 8'd7;
			8'd69: sample <= 8'd7;
			8'd70: sample <= 8'd7;
			8'd71: sample <= 8'd6;
			8'd72: sample <= 8'd7;
			8'd73: sample <= 8'd6;
			8'd74: sample <= 8'd6;
			8'd75: sample <= 8'd6;
			8'd76: sample <= 8'd6;
			8'd77: sample <= 8'd6;
			8'd78: sample <= 8'd6;
			8'd79: sample <= 8'd6;
			8'd80: sample <= 8'd6;
			8'd81: sample <= 8'd6;
			8'd82: sample <= 8'd6;
			8'd83: sample <= 8'd6;
			8'd84: sample <= 8'd6;
			8'd85: sample <= 8'd6;
			8'd86: sample <= 8'd6;
			8'd87: sample <= 8'd6;
			8'd88: sample <= 8'd6;
			8'd89: sample <= 8'd6;
			8'd90: sample <= 8'd6;
			8'd91: sample <= 8'd6;
			8'd92: sample <= 8'd6;
			8'd93: sample <= 8'd6;
			8'd94: sample <= 8'd6;
			8'd95: sample <= 8'd6;
			8'd96: sample <= 8'd6;
			8'd97: sample <= 8'd6;
			8'd98: sample <= 8'd6;
			8'd99: sample <= 8'd6;
			8'd100: sample <= 8'd6;
			8'd101: sample <= 8'd6;
			8'd102: sample <= 8'd6;
			8'd103: sample <= 8'd6;
			8'd104: sample <= 8'd6;
			8'd105: sample <= 8'd6;
			8'd106: sample <= 8'd7; // P wave
			8'd107: sample <= 8'd8;
			8'd108: sample <= 8'd10;
			8'd109: sample <= 8'd11;
			8'd110: sample <= 8'd12;
			8'd111: sample <= 8'd14;
			8'd112: sample <= 8'd15;
			8'd113: sample <= 8'd14;
			8'd114: sample <= 8'd14;
			8'd115: sample <= 8'd12;
			8'd116: sample <= 8'd11;
			8'd117: sample <= 8'd10;
			8'd118: sample <= 8'd7;
			8'd119: sample <= 8'd6;
			8'd120: sample <= 8'd5;
			8'd121: sample <= 8'd5;
			8'd122: sample <= 8'd5;
			8'd123: sample <= 8'd5;
			8'd124: sample <= 8'd5;
			8'd125: sample <= 8'd3;
			8'd126: sample <= 8'd5;
			8'd127: sample <= 8'd17; // Second QRS complex
			8'd128: sample <= 8'd46;
			8'd129: sample <= 8'd64;
			8'd130: sample <= 8'd58;
			8'd131: sample <= 8'd31;
			8'd132: sample <= 8'd14;
			8'd133: sample <= 8'd2;
			8'd134: sample <= 8'd3;
			8'd135: sample <= 8'd7;
			8'd136: sample <= 8'd8;
			8'd137: sample <= 8'd7;
			8'd138: sample <= 8'd8;
			8'd139: sample <= 8'd8;
			8'd140: sample <= 8'd8;
			8'd141: sample <= 8'd8;
			8'd142: sample <= 8'd9;
			8'd143: sample <= 8'd9;
			8'd144: sample <= 8'd9;
			8'd145: sample <= 8'd10;
			8'd146: sample <= 8'd10;
			8'd147: sample <= 8'd10;
			8'd148: sample <= 8'd11;
			8'd149: sample <= 8'd11;
			8'd150: sample <= 8'd12;
			8'd151: sample <= 8'd12;
			8'd152: sample <= 8'd13;
			8'd153: sample <= 8'd14;
			8'd154: sample <= 8'd0; // Padding to the end of the record
			8'd155: sample <= 8'd0;
			8'd156: sample <= 8'd0;
			8'd157: sample <= 8'd0;
			8'd158: sample <= 8'd0;
			8'd159: sample <= 8'd0;
			8'd160: sample <= 8'd0;
			8'd161: sample <= 8'd0;
			8'd162: sample <= 8'd0;
			8'd163: sample <= 8'd0;
			8'd164: sample <= 8'd0;
			8'd165: sample <= 8'd0;
			8'd166: sample <= 8'd0;
			8'd167: sample <= 8'd0;
			8'd168: sample <= 8'd0;
			8'd169: sample <= 8'd0;
			8'd170: sample <= 8'd0;
			8'd171: sample <= 8'd0;
			8'd172: sample <= 8'd0;
			8'd173: sample <= 8'd0;
			8'd174: sample <= 8'd0;
			8'd175: sample <= 8'd0;
			8'd176: sample <= 8'd0;
			8'd177: sample <= 8'd0;
			8'd178: sample <= 8'd0;
			8'd179: sample <= 8'd0;
			8'd180: sample <= 8'd0;
			8'd181: sample <= 8'd0;
			8'd182: sample <= 8'd0;
			8'd183: sample <= 8'd0;
			8'd184: sample <= 8'd0;
			8'd185: sample <= 8'd0;
			8'd186: sample <= 8'd0;
			default: sample <= '0;
		endcase
	end

endmodule

/* hw/ecgSequencer.sv */
`timescale 1ns/10ps

module ecgSequencer
(
	input logic clk,
	input logic rstN,
	input logic start,
	output logic [ecgPkg::AddrWidth-1:0] addr,
	output logic busy,
	output logic done,
	ecgStreamIf.source stream
);

	logic launch; // First read goes out on the next cycle
	logic issue;  // addr holds a live ROM read
	logic lastAddr;

	assign lastAddr = (addr == ecgPkg::AddrWidth'(ecgPkg::NumSamples - 1));

	// Run control and address counter
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			launch <= 1'b0;
			issue <= 1'b0;
			addr <= '0;
		end
		else
		begin
			launch <= start && !busy;
			if (start && !busy)
				busy <= 1'b1;
			else if (stream.last)
				busy <= 1'b0; // Falls together with done
			if (launch)
			begin
				issue <= 1'b1;
				addr <= '0;
			end
			else if (issue)
			begin
				if (lastAddr)
					issue <= 1'b0;
				else
					addr <= addr + 1'b1;
			end
		end
	end

	// In-flight stage lines up with the ROM output register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			stream.valid <= 1'b0;
			stream.last <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			stream.valid <= issue;
			stream.last <= issue && lastAddr;
			done <= stream.last;
		end
	end

	always_ff @(posedge clk)
		stream.index <= addr;

endmodule

/* hw/rPeakDetector.sv */
`timescale 1ns/10ps

module rPeakDetector
(
	input logic clk,
	input logic rstN,
	input logic runStart,
	ecgStreamIf.sink stream,
	output logic peakValid,
	output logic [ecgPkg::AddrWidth-1:0] peakIndex,
	output logic [ecgPkg::SampleWidth-1:0] peakAmplitude,
	output logic [ecgPkg::RrWidth-1:0] rrInterval,
	output logic [ecgPkg::AddrWidth-1:0] peakCount
);

	logic [ecgPkg::SampleWidth-1:0] prevSample; // Sample n-1
	logic [ecgPkg::SampleWidth-1:0] candSample; // Sample n judged against the incoming one
	logic [ecgPkg::AddrWidth-1:0] candIndex;
	logic haveCand;
	logic havePeak; // Earlier peak seen in this run
	logic [ecgPkg::RrWidth-1:0] refractory;
	logic [ecgPkg::RrWidth-1:0] sinceLast; // Samples since the last reported peak
	logic isPeak;

	// Local maximum above threshold and outside the blanking window
	assign isPeak = stream.valid && haveCand
		&& (candSample >= ecgPkg::PeakThreshold)
		&& (candSample > prevSample)
		&& (candSample >= stream.sample)
		&& (refractory == '0);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			haveCand <= 1'b0;
			havePeak <= 1'b0;
			refractory <= '0;
			sinceLast <= '0;
			peakValid <= 1'b0;
			peakCount <= '0;
		end
		else if (runStart)
		begin
			haveCand <= 1'b0;
			havePeak <= 1'b0;
			refractory <= '0;
			sinceLast <= '0;
			peakValid <= 1'b0;
			peakCount <= '0;
		end
		else
		begin
			peakValid <= isPeak;
			if (stream.valid)
			begin
				haveCand <= 1'b1;
				if (isPeak)
				begin
					havePeak <= 1'b1;
					refractory <= ecgPkg::RefractorySamples;
					sinceLast <= ecgPkg::RrWidth'(1);
					peakCount <= peakCount + 1'b1;
				end
				else
				begin
					if (refractory != '0)
						refractory <= refractory - 1'b1;
					if (sinceLast != '1)
						sinceLast <= sinceLast + 1'b1; // Saturates on long gaps
				end
			end
		end
	end

	// Sample history and peak report
	always_ff @(posedge clk)
	begin
		if (runStart)
		begin
			prevSample <= '0;
			candSample <= '0; // Index 0 sees a zero predecessor
		end
		else if (stream.valid)
		begin
			prevSample <= candSample;
			candSample <= stream.sample;
			candIndex <= stream.index;
		end
		if (isPeak)
		begin
			peakIndex <= candIndex;
			peakAmplitude <= candSample;
			rrInterval <= havePeak ? sinceLast : '0;
		end
	end

endmodule

/* hw/ecgTop.sv */
`timescale 1ns/10ps

module ecgTop
(
	input logic clk,
	input logic rstN,
	input logic start,
	output logic busy,
	output logic done,
	output logic sampleValid,
	output logic [ecgPkg::AddrWidth-1:0] sampleIndex,
	output logic [ecgPkg::SampleWidth-1:0] sample,
	output logic peakValid,
	output logic [ecgPkg::AddrWidth-1:0] peakIndex,
	output logic [ecgPkg::SampleWidth-1:0] peakAmplitude,
	output logic [ecgPkg::RrWidth-1:0] rrInterval,
	output logic [ecgPkg::AddrWidth-1:0] peakCount
);

	ecgStreamIf stream();

	logic [ecgPkg::AddrWidth-1:0] romAddr;
	logic busyQ;
	logic runStart;

	// Accepted start shows up as the rise of busy
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			busyQ <= 1'b0;
		else
			busyQ <= busy;
	end

	assign runStart = busy && !busyQ;

	ecgSequencer i_ecgSequencer
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.addr(romAddr),
		.busy(busy),
		.done(done),
		.stream(stream.source)
	);

	ecgSampleRom i_ecgSampleRom
	(
		.clk(clk),
		.addr(romAddr),
		.sample(stream.sample)
	);

	rPeakDetector i_rPeakDetector
	(
		.clk(clk),
		.rstN(rstN),
		.runStart(runStart),
		.stream(stream.sink),
		.peakValid(peakValid),
		.peakIndex(peakIndex),
		.peakAmplitude(peakAmplitude),
		.rrInterval(rrInterval),
		.peakCount(peakCount)
	);

	assign sampleValid = stream.valid;
	assign sampleIndex = stream.index;
	assign sample = stream.sample;

endmodule

/* verification/clockGen.sv */
`timescale 1ns/10ps

module clockGen
(
	input logic resetReq,
	output logic clk,
	output logic rstN
);

	logic porDone; // Power-on reset over

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial
	begin
		porDone = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		porDone = 1'b1;
	end

	assign rstN = porDone && !resetReq; // resetReq pulls reset in the middle of a run

endmodule

/* verification/ecgTb.sv */
`timescale 1ns/10ps

module ecgTb;

	localparam int MaxPeaks = 2;
	localparam int TestDataWords = ecgPkg::NumSamples + 1 + 3 * MaxPeaks;
	localparam int DataAddrWidth = $clog2(TestDataWords);
	localparam int CountPos = ecgPkg::NumSamples; // Peak count follows the samples
	localparam int RunCycles = ecgPkg::NumSamples + 10;
	localparam int CycleLimit = 3 * RunCycles + 50;

	logic clk;
	logic rstN;
	logic resetReq;
	logic start;
	logic busy;
	logic done;
	logic sampleValid;
	logic [ecgPkg::AddrWidth-1:0] sampleIndex;
	logic [ecgPkg::SampleWidth-1:0] sample;
	logic peakValid;
	logic [ecgPkg::AddrWidth-1:0] peakIndex;
	logic [ecgPkg::SampleWidth-1:0] peakAmplitude;
	logic [ecgPkg::RrWidth-1:0] rrInterval;
	logic [ecgPkg::AddrWidth-1:0] peakCount;

	logic [ecgPkg::SampleWidth-1:0] testData [0:TestDataWords-1];
	int seed;
	int expPeaks;
	int gap;
	int cycleCount = 0;

	clockGen i_clockGen
	(
		.resetReq(resetReq),
		.clk(clk),
		.rstN(rstN)
	);

	ecgTop i_ecgTop
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.busy(busy),
		.done(done),
		.sampleValid(sampleValid),
		.sampleIndex(sampleIndex),
		.sample(sample),
		.peakValid(peakValid),
		.peakIndex(peakIndex),
		.peakAmplitude(peakAmplitude),
		.rrInterval(rrInterval),
		.peakCount(peakCount)
	);

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: the runs did not finish within %0d cycles", CycleLimit);
			$display("Regression failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic checkValue(input int actual, input int expected, input string what);
		if (actual != expected)
		begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int dataWord(input int pos);
		return int'(testData[DataAddrWidth'(pos)]);
	endfunction

	// Quiet cycles between runs while peakCount holds
	task automatic checkIdle(input int cycles, input int holdCount);
		repeat (cycles)
		begin
			@(negedge clk);
			checkValue(int'(busy), 0, "busy while idle");
			checkValue(int'(done), 0, "done while idle");
			checkValue(int'(sampleValid), 0, "sampleValid while idle");
			checkValue(int'(peakValid), 0, "peakValid while idle");
			checkValue(int'(peakCount), holdCount, "peakCount while idle");
		end
	endtask

	// Full run with an extra start pulse at cycle pokeAt when nonzero
	task automatic runAndCheck(input int pokeAt);
		int cyc;
		int nextIndex;
		int peakNum;
		int base;
		logic prevValid;
		logic finished;
		cyc = 0;
		nextIndex = 0;
		peakNum = 0;
		prevValid = 1'b0;
		finished = 1'b0;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!finished)
		begin
			if (cyc == 1)
				checkValue(int'(peakCount), 0, "peakCount after start");
			if (sampleValid)
			begin
				checkValue(cyc, 2 + nextIndex, "cycles from start to sample");
				checkValue(int'(sampleIndex), nextIndex, "sampleIndex");
				checkValue(int'(sample), dataWord(nextIndex), "sample");
				nextIndex++;
			end
			if (peakValid)
			begin
				if (peakNum >= expPeaks)
					checkValue(peakNum + 1, expPeaks, "peaks reported");
				base = CountPos + 1 + 3 * peakNum;
				checkValue(cyc, dataWord(base) + 4, "cycles from start to peak");
				checkValue(int'(peakIndex), dataWord(base), "peakIndex");
				checkValue(int'(peakAmplitude), dataWord(base + 1), "peakAmplitude");
				checkValue(int'(rrInterval), dataWord(base + 2), "rrInterval");
				checkValue(int'(peakCount), peakNum + 1, "peakCount at peak");
				peakNum++;
			end
			if (done)
			begin
				checkValue(int'(prevValid), 1, "sample on the cycle before done");
				checkValue(int'(sampleValid), 0, "sampleValid with done");
				checkValue(int'(busy), 0, "busy with done");
				checkValue(nextIndex, ecgPkg::NumSamples, "samples in the run");
				checkValue(peakNum, expPeaks, "peaks in the run");
				checkValue(int'(peakCount), expPeaks, "peakCount at done");
				finished = 1'b1;
			end
			else
			begin
				checkValue(int'(busy), 1, "busy during run");
				prevValid = sampleValid;
				cyc++;
				start = (cyc == pokeAt); // Should be ignored while busy
				@(negedge clk);
			end
		end
	endtask

	task automatic resetMidRun(input int abortAt);
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (abortAt) @(negedge clk);
		checkValue(int'(sampleValid), 1, "stream running before reset");
		checkValue(int'(peakCount != '0), 1, "peak seen before reset");
		resetReq = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			checkValue(int'(busy), 0, "busy in reset");
			checkValue(int'(done), 0, "done in reset");
			checkValue(int'(sampleValid), 0, "sampleValid in reset");
			checkValue(int'(peakValid), 0, "peakValid in reset");
			checkValue(int'(peakCount), 0, "peakCount in reset");
		end
		resetReq = 1'b0;
	endtask

	initial
	begin
		start = 1'b0;
		resetReq = 1'b0;
		seed = 23;
		$readmemh("verification/ecgTestdata.hex", testData);
		if ($isunknown(testData[DataAddrWidth'(CountPos)]))
		begin
			$display("The test data file could not be read");
			$display("Regression failed");
			$fatal(1, "missing test data");
		end
		expPeaks = dataWord(CountPos);
		wait (rstN === 1'b1);
		checkIdle(1, 0);
		runAndCheck(60);
		gap = ($random(seed) & 3) + 1;
		checkIdle(gap, expPeaks); // No second run may follow the ignored start
		runAndCheck(0);
		checkIdle(1, expPeaks);
		resetMidRun(30);
		checkIdle(1, 0);
		runAndCheck(0);
		checkIdle(1, expPeaks);
		$display("Regression passed");
		$finish;
	end

endmodule

/* verification/ecgTestdata.hex */
// Words 0..186: stored samples in index order, eight per line
// Then the peak count, then index amplitude RR for each peak
3d 3c 29 13 04 00 03 06
06 06 06 06 07 07 07 08
08 08 08 08 09 0a 0a 0b
0b 0c 0d 0e 0f 11 12 14
15 16 17 17 17 16 15 13
10 0e 0c 0b 09 09 08 07
07 07 07 07 07 07 07 07
07 07 07 07 07 07 07 07
07 07 07 07 07 07 07 06
07 06 06 06 06 06 06 06
06 06 06 06 06 06 06 06
06 06 06 06 06 06 06 06
06 06 06 06 06 06 06 06
06 06 07 08 0a 0b 0c 0e
0f 0e 0e 0c 0b 0a 07 06
05 05 05 05 05 03 05 11
2e 40 3a 1f 0e 02 03 07
08 07 08 08 08 08 09 09
09 0a 0a 0a 0b 0b 0c 0c
0d 0e 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00
02
00 3d 00
81 40 81

/* sim.f */
hw/ecgPkg.sv
hw/ecgStreamIf.sv
hw/ecgSampleRom.sv
hw/ecgSequencer.sv
hw/rPeakDetector.sv
hw/ecgTop.sv
verification/clockGen.sv
verification/ecgTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
TOP ?= ecgTb
FILELIST ?= sim.f
OBJDIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
